// File: hw/soc_bus_pkg.sv
// peripheral bus package: APB widths, window map and error response constants
`default_nettype none

package soc_bus_pkg;

	// ------------------------------------------------------------------
	// APB widths

	// peripheral bus address, 16 bits as seen inside each device
	localparam int APB_ADDR_W = 16;

	// data bus, one full word per transfer
	localparam int APB_DATA_W = 32;

	typedef logic [APB_ADDR_W-1:0] apb_addr_t;
	typedef logic [APB_DATA_W-1:0] apb_data_t;

	// ------------------------------------------------------------------
	// address windows

	// window select uses paddr[15:14]
	localparam apb_addr_t TIMER_WIN_MASK = 16'hc000;

	// timer sits in the first window, 0x0000 to 0x3fff
	localparam apb_addr_t TIMER_WIN_BASE = 16'h0000;

	// all other windows are unmapped and answer with an error

	// ------------------------------------------------------------------
	// response constants

	// read data returned with pslverr
	localparam apb_data_t APB_ERR_RDATA = 32'h0000_0000;

endpackage

`default_nettype wire

// File: hw/timer_pkg.sv
// system timer package: register map, register select enum, reset values, timebase
`default_nettype none

package timer_pkg;

	// ------------------------------------------------------------------
	// register map

	// low offset bits decoded, higher bits in the window must be zero
	localparam int TIMER_OFS_W = 8;

	localparam logic [TIMER_OFS_W-1:0] TIMER_OFS_CTRL      = 8'h00;
	localparam logic [TIMER_OFS_W-1:0] TIMER_OFS_MTIME     = 8'h08;
	localparam logic [TIMER_OFS_W-1:0] TIMER_OFS_MTIMEH    = 8'h0c;
	localparam logic [TIMER_OFS_W-1:0] TIMER_OFS_MTIMECMP  = 8'h10;
	localparam logic [TIMER_OFS_W-1:0] TIMER_OFS_MTIMECMPH = 8'h14;

	// register targeted by a decoded access
	typedef enum logic [2:0] {
		TREG_CTRL,
		TREG_MTIME,
		TREG_MTIMEH,
		TREG_MTIMECMP,
		TREG_MTIMECMPH,
		TREG_NONE
	} timer_reg_e;

	// ------------------------------------------------------------------
	// counter and reset values

	localparam int MTIME_W      = 64;
	localparam int MTIME_HALF_W = MTIME_W / 2;
	typedef logic [MTIME_W-1:0] mtime_t;

	// compare starts at max so no interrupt fires out of reset
	localparam mtime_t MTIMECMP_RESET = {MTIME_W{1'b1}};

	// counter runs out of reset
	localparam logic CTRL_EN_RESET = 1'b1;

	// clock cycles per microsecond tick
	localparam int CLK_MHZ    = 27;
	localparam int TICK_CNT_W = $clog2(CLK_MHZ);

endpackage

`default_nettype wire

// File: hw/timer_req_if.sv
// decoded timer register access, carried from APB decode to the timer register file
`timescale 1ns/1ps
`default_nettype none

interface timer_req_if;
	import timer_pkg::*;

	// one-cycle access pulse, no back-pressure
	logic strobe;

	// 1 for a write, 0 for a read
	logic write;

	// target register of this access
	timer_reg_e reg_sel;

	// write data, one 32-bit half of a timer register
	logic [MTIME_HALF_W-1:0] wdata;

	// read data, combinational from reg_sel
	logic [MTIME_HALF_W-1:0] rdata;

	modport decoder (
		output strobe,
		output write,
		output reg_sel,
		output wdata
	);

	modport timer (
		input  strobe,
		input  write,
		input  reg_sel,
		input  wdata,
		output rdata
	);

endinterface

`default_nettype wire

// File: hw/apb_decode.sv
// APB access decode: maps an access phase onto a timer register strobe or an error
`timescale 1ns/1ps
`default_nettype none

module apb_decode (
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  soc_bus_pkg::apb_addr_t paddr,
	input  soc_bus_pkg::apb_data_t pwdata,
	input  logic                  pready,
	output logic                  err,
	timer_req_if.decoder          req
);
	import soc_bus_pkg::*;
	import timer_pkg::*;

	logic                   access;
	logic                   in_window;
	apb_addr_t              win_ofs;
	logic                   upper_zero;
	logic [TIMER_OFS_W-1:0] ofs;
	timer_reg_e             sel;
	logic                   hit;

	// first access cycle only, the response is still pending
	assign access = psel & penable & ~pready;

	// ------------------------------------------------------------------
	// address match

	assign in_window  = (paddr & TIMER_WIN_MASK) == TIMER_WIN_BASE;
	assign win_ofs    = paddr & ~TIMER_WIN_MASK;
	assign upper_zero = (win_ofs >> TIMER_OFS_W) == '0;
	assign ofs        = win_ofs[TIMER_OFS_W-1:0];

	always_comb begin
		case (ofs)
			TIMER_OFS_CTRL:      sel = TREG_CTRL;
			TIMER_OFS_MTIME:     sel = TREG_MTIME;
			TIMER_OFS_MTIMEH:    sel = TREG_MTIMEH;
			TIMER_OFS_MTIMECMP:  sel = TREG_MTIMECMP;
			TIMER_OFS_MTIMECMPH: sel = TREG_MTIMECMPH;
			default:             sel = TREG_NONE;
		endcase
		// aliases above the decoded offset are unmapped
		if (!upper_zero) begin
			sel = TREG_NONE;
		end
	end

	assign hit = in_window && (sel != TREG_NONE);

	// ------------------------------------------------------------------
	// outputs

	// unmapped access gets err and no strobe, so nothing is written
	assign req.strobe  = access & hit;
	assign err         = access & ~hit;
	assign req.write   = pwrite;
	assign req.reg_sel = sel;
	assign req.wdata   = pwdata;

endmodule

`default_nettype wire

// File: hw/timebase_tick.sv
// microsecond timebase: one-cycle tick every CLK_MHZ clock cycles
`timescale 1ns/1ps
`default_nettype none

module timebase_tick (
	input  logic clk,
	input  logic rst_n,
	output logic tick
);
	import timer_pkg::*;

	logic [TICK_CNT_W-1:0] tick_cnt;

	// down counter, reload on zero
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tick_cnt <= '0;
			tick     <= 1'b0;
		end else begin
			if (|tick_cnt) begin
				tick_cnt <= tick_cnt - 1'b1;
			end else begin
				tick_cnt <= TICK_CNT_W'(CLK_MHZ - 1);
			end
			// registered pulse, one cycle after the counter hits zero
			tick <= ~|tick_cnt;
		end
	end

endmodule

`default_nettype wire

// File: hw/timer_regs.sv
// system timer register file: enable, 64-bit mtime and mtimecmp, registered interrupt
`timescale 1ns/1ps
`default_nettype none

module timer_regs (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        tick,
	input  logic        dbg_halt,
	timer_req_if.timer  req,
	output logic        timer_irq
);
	import timer_pkg::*;

	logic   ctrl_en;
	mtime_t mtime;
	mtime_t mtimecmp;
	logic   wr;
	logic   count_en;

	assign wr = req.strobe & req.write;

	// counting stops while the hart is halted by the debugger
	assign count_en = tick & ctrl_en & ~dbg_halt;

	// ------------------------------------------------------------------
	// control

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_en <= CTRL_EN_RESET;
		end else if (wr && req.reg_sel == TREG_CTRL) begin
			ctrl_en <= req.wdata[0];
		end
	end

	// ------------------------------------------------------------------
	// mtime

	// a software write wins over a tick in the same cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtime <= '0;
		end else if (wr && req.reg_sel == TREG_MTIME) begin
			mtime[MTIME_HALF_W-1:0] <= req.wdata;
		end else if (wr && req.reg_sel == TREG_MTIMEH) begin
			mtime[MTIME_W-1:MTIME_HALF_W] <= req.wdata;
		end else if (count_en) begin
			mtime <= mtime + 1'b1;
		end
	end

	// ------------------------------------------------------------------
	// mtimecmp

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtimecmp <= MTIMECMP_RESET;
		end else if (wr && req.reg_sel == TREG_MTIMECMP) begin
			mtimecmp[MTIME_HALF_W-1:0] <= req.wdata;
		end else if (wr && req.reg_sel == TREG_MTIMECMPH) begin
			mtimecmp[MTIME_W-1:MTIME_HALF_W] <= req.wdata;
		end
	end

	// ------------------------------------------------------------------
	// interrupt

	// level interrupt, follows the compare one cycle late
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			timer_irq <= 1'b0;
		end else begin
			timer_irq <= ctrl_en && (mtime >= mtimecmp);
		end
	end

	// ------------------------------------------------------------------
	// read mux

	// write transfers return zero read data
	always_comb begin
		req.rdata = '0;
		if (!req.write) begin
			case (req.reg_sel)
				TREG_CTRL:      req.rdata = {{(MTIME_HALF_W-1){1'b0}}, ctrl_en};
				TREG_MTIME:     req.rdata = mtime[MTIME_HALF_W-1:0];
				TREG_MTIMEH:    req.rdata = mtime[MTIME_W-1:MTIME_HALF_W];
				TREG_MTIMECMP:  req.rdata = mtimecmp[MTIME_HALF_W-1:0];
				TREG_MTIMECMPH: req.rdata = mtimecmp[MTIME_W-1:MTIME_HALF_W];
				default:        req.rdata = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/apb_response.sv
// APB response stage: registers pready, prdata and pslverr for each completed access
`timescale 1ns/1ps
`default_nettype none

module apb_response (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  strobe,
	input  logic                  err,
	input  soc_bus_pkg::apb_data_t rdata,
	output logic                  pready,
	output soc_bus_pkg::apb_data_t prdata,
	output logic                  pslverr
);
	import soc_bus_pkg::*;

	logic done;

	// an access finishes on either a good strobe or a decode error
	assign done = strobe | err;

	// ------------------------------------------------------------------
	// handshake

	// pready high for exactly one cycle, the cycle after the access starts
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pready  <= 1'b0;
			pslverr <= 1'b0;
		end else begin
			pready  <= done;
			pslverr <= err;
		end
	end

	// ------------------------------------------------------------------
	// read data

	// bus stays at zero outside the completing cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prdata <= '0;
		end else if (err) begin
			prdata <= APB_ERR_RDATA;
		end else if (strobe) begin
			// timer already returns zero for writes
			prdata <= rdata;
		end else begin
			prdata <= '0;
		end
	end

endmodule

`default_nettype wire

// File: hw/periph_top.sv
// peripheral top level: APB completer with the microsecond timebase and system timer
`timescale 1ns/1ps
`default_nettype none

module periph_top (
	input  logic                  clk,
	input  logic                  rst_n,

	// APB completer
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  soc_bus_pkg::apb_addr_t paddr,
	input  soc_bus_pkg::apb_data_t pwdata,
	output soc_bus_pkg::apb_data_t prdata,
	output logic                  pready,
	output logic                  pslverr,

	// timer side
	input  logic                  dbg_halt,
	output logic                  timer_irq
);

	logic dec_err;
	logic us_tick;

	timer_req_if req_bus ();

	// ------------------------------------------------------------------
	// decode

	apb_decode decode_u (
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.pready  (pready),
		.err     (dec_err),
		.req     (req_bus.decoder)
	);

	// ------------------------------------------------------------------
	// timebase and timer

	timebase_tick tick_u (
		.clk   (clk),
		.rst_n (rst_n),
		.tick  (us_tick)
	);

	timer_regs timer_u (
		.clk       (clk),
		.rst_n     (rst_n),
		.tick      (us_tick),
		.dbg_halt  (dbg_halt),
		.req       (req_bus.timer),
		.timer_irq (timer_irq)
	);

	// ------------------------------------------------------------------
	// response

	apb_response resp_u (
		.clk     (clk),
		.rst_n   (rst_n),
		.strobe  (req_bus.strobe),
		.err     (dec_err),
		.rdata   (req_bus.rdata),
		.pready  (pready),
		.prdata  (prdata),
		.pslverr (pslverr)
	);

endmodule

`default_nettype wire

// File: tb/periph_assert.sv
// APB response and timer interrupt checks bound into the peripheral top level
`timescale 1ns/1ps
`default_nettype none

module periph_assert (
	input logic                   clk,
	input logic                   rst_n,
	input logic                   psel,
	input logic                   penable,
	input logic                   pwrite,
	input logic                   pready,
	input logic                   pslverr,
	input soc_bus_pkg::apb_data_t prdata,
	input logic                   dbg_halt,
	input logic                   timer_irq
);

	// first access cycle with the response not yet given
	logic access_start;

	assign access_start = psel & penable & ~pready;

	// ------------------------------------------------------------------
	// APB response

	pready_single: assert property (@(posedge clk) disable iff (!rst_n)
		pready |=> !pready)
		else $error("pready high for two cycles in a row");

	resp_only_with_ready: assert property (@(posedge clk) disable iff (!rst_n)
		(pslverr || (prdata != '0)) |-> pready)
		else $error("pslverr or prdata active without pready");

	one_wait_state: assert property (@(posedge clk) disable iff (!rst_n)
		access_start |=> pready)
		else $error("pready did not follow the first access cycle");

	// ------------------------------------------------------------------
	// timer interrupt

	// a halted cycle without a write leaves the compare inputs unchanged
	irq_held_while_halted: assert property (@(posedge clk) disable iff (!rst_n)
		(dbg_halt && !(access_start && pwrite)) |=> ##1 $stable(timer_irq))
		else $error("timer_irq changed while halted without a write");

endmodule

bind periph_top periph_assert periph_assert_u (
	.clk       (clk),
	.rst_n     (rst_n),
	.psel      (psel),
	.penable   (penable),
	.pwrite    (pwrite),
	.pready    (pready),
	.pslverr   (pslverr),
	.prdata    (prdata),
	.dbg_halt  (dbg_halt),
	.timer_irq (timer_irq)
);

`default_nettype wire

// File: tb/tb_periph.sv
// directed APB tests of the system timer behind the peripheral top level
`timescale 1ns/1ps
`default_nettype none

module tb_periph;
	import soc_bus_pkg::*;

	// timer register addresses
	localparam apb_addr_t ADDR_CTRL      = 16'h0000;
	localparam apb_addr_t ADDR_MTIME     = 16'h0008;
	localparam apb_addr_t ADDR_MTIMEH    = 16'h000c;
	localparam apb_addr_t ADDR_MTIMECMP  = 16'h0010;
	localparam apb_addr_t ADDR_MTIMECMPH = 16'h0014;

	localparam int PREADY_TIMEOUT = 20;
	localparam int IRQ_TIMEOUT    = 500;

	logic      clk;
	logic      rst_n;
	logic      psel;
	logic      penable;
	logic      pwrite;
	apb_addr_t paddr;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic      pready;
	logic      pslverr;
	logic      dbg_halt;
	logic      timer_irq;

	int          errors;
	int          checks;
	logic [31:0] rng;

	// expected mtimecmp halves after the read-back test
	apb_data_t exp_cmp_lo;
	apb_data_t exp_cmp_hi;

	periph_top dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.dbg_halt  (dbg_halt),
		.timer_irq (timer_irq)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ------------------------------------------------------------------
	// helpers

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_data(input string name, input apb_data_t exp, input apb_data_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED t=%0t %s expected %b actual %b", $time, name, exp, act);
		end
	endtask

	task automatic report_and_finish();
		$display("checks: %0d errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	// ------------------------------------------------------------------
	// APB driver entered 1 ns after a rising edge

	task automatic apb_transfer(input logic write, input apb_addr_t addr,
		input apb_data_t wdata, output apb_data_t rdata, output logic slverr);
		int waits;
		// setup phase
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge clk);
		#1;
		penable = 1'b1;
		check_bit("pready", 1'b0, pready);
		waits = 0;
		do begin
			@(posedge clk);
			#1;
			waits++;
		end while (!pready && waits < PREADY_TIMEOUT);
		if (!pready) begin
			$display("ERROR: pready never rose for address %h", addr);
			errors++;
			report_and_finish();
		end else begin
			checks++;
			if (waits != 1) begin
				errors++;
				$display("CHECK FAILED t=%0t pready_delay expected 1 actual %0d", $time, waits);
			end
			rdata  = prdata;
			slverr = pslverr;
			@(posedge clk);
			#1;
			psel    = 1'b0;
			penable = 1'b0;
			pwrite  = 1'b0;
			paddr   = '0;
			pwdata  = '0;
			@(posedge clk);
			#1;
		end
	endtask

	task automatic apb_write(input apb_addr_t addr, input apb_data_t data, input logic exp_err);
		apb_data_t rd;
		logic      err;
		apb_transfer(1'b1, addr, data, rd, err);
		check_bit("pslverr", exp_err, err);
		check_data("prdata", '0, rd);
	endtask

	task automatic apb_read(input apb_addr_t addr, output apb_data_t data, input logic exp_err);
		logic err;
		apb_transfer(1'b0, addr, '0, data, err);
		check_bit("pslverr", exp_err, err);
	endtask

	task automatic wait_irq(input logic level);
		int n;
		n = 0;
		while (timer_irq !== level && n < IRQ_TIMEOUT) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (timer_irq !== level) begin
			$display("ERROR: timer_irq did not reach %b in time", level);
			errors++;
			report_and_finish();
		end else begin
			checks++;
		end
	endtask

	// ------------------------------------------------------------------
	// directed tests

	task automatic test_reset_values();
		apb_data_t rd;
		apb_read(ADDR_CTRL, rd, 1'b0);
		check_data("ctrl", 32'h1, rd);
		apb_read(ADDR_MTIMECMP, rd, 1'b0);
		check_data("mtimecmp", 32'hffff_ffff, rd);
		apb_read(ADDR_MTIMECMPH, rd, 1'b0);
		check_data("mtimecmph", 32'hffff_ffff, rd);
		check_bit("timer_irq", 1'b0, timer_irq);
	endtask

	task automatic test_write_readback();
		apb_data_t rd;
		apb_data_t lo;
		apb_data_t hi;
		rng = xorshift32(rng);
		exp_cmp_lo = rng;
		rng = xorshift32(rng);
		exp_cmp_hi = rng;
		apb_write(ADDR_MTIMECMP, exp_cmp_lo, 1'b0);
		apb_write(ADDR_MTIMECMPH, exp_cmp_hi, 1'b0);
		apb_read(ADDR_MTIMECMP, rd, 1'b0);
		check_data("mtimecmp", exp_cmp_lo, rd);
		apb_read(ADDR_MTIMECMPH, rd, 1'b0);
		check_data("mtimecmph", exp_cmp_hi, rd);
		// counter stopped so mtime holds the written value
		apb_write(ADDR_CTRL, 32'h0, 1'b0);
		rng = xorshift32(rng);
		lo = rng;
		rng = xorshift32(rng);
		hi = rng;
		apb_write(ADDR_MTIME, lo, 1'b0);
		apb_write(ADDR_MTIMEH, hi, 1'b0);
		apb_read(ADDR_MTIME, rd, 1'b0);
		check_data("mtime", lo, rd);
		apb_read(ADDR_MTIMEH, rd, 1'b0);
		check_data("mtimeh", hi, rd);
	endtask

	task automatic test_error_response();
		apb_data_t rd;
		apb_read(16'h0004, rd, 1'b1);
		check_data("prdata", '0, rd);
		apb_write(16'h0018, 32'h1234_5678, 1'b1);
		apb_read(16'h4000, rd, 1'b1);
		check_data("prdata", '0, rd);
		// outside the window at the low offsets of real registers
		apb_write(16'h4000, 32'h1, 1'b1);
		apb_write(16'h4010, ~exp_cmp_lo, 1'b1);
		// alias above the decoded offset bits
		apb_write(16'h0110, ~exp_cmp_lo, 1'b1);
		apb_read(ADDR_CTRL, rd, 1'b0);
		check_data("ctrl", 32'h0, rd);
		apb_read(ADDR_MTIMECMP, rd, 1'b0);
		check_data("mtimecmp", exp_cmp_lo, rd);
	endtask

	task automatic test_count_halt();
		apb_data_t first;
		apb_data_t second;
		apb_write(ADDR_MTIME, 32'h0, 1'b0);
		apb_write(ADDR_MTIMEH, 32'h0, 1'b0);
		apb_write(ADDR_CTRL, 32'h1, 1'b0);
		apb_read(ADDR_MTIME, first, 1'b0);
		idle_cycles(100);
		apb_read(ADDR_MTIME, second, 1'b0);
		check_bit("mtime_advanced", 1'b1, second > first);
		// halted by the debugger
		dbg_halt = 1'b1;
		apb_read(ADDR_MTIME, first, 1'b0);
		idle_cycles(100);
		apb_read(ADDR_MTIME, second, 1'b0);
		check_data("mtime", first, second);
		dbg_halt = 1'b0;
		// disabled by software
		apb_write(ADDR_CTRL, 32'h0, 1'b0);
		apb_read(ADDR_MTIME, first, 1'b0);
		idle_cycles(100);
		apb_read(ADDR_MTIME, second, 1'b0);
		check_data("mtime", first, second);
	endtask

	task automatic test_interrupt();
		apb_write(ADDR_MTIME, 32'd10, 1'b0);
		apb_write(ADDR_MTIMEH, 32'h0, 1'b0);
		apb_write(ADDR_MTIMECMPH, 32'h0, 1'b0);
		apb_write(ADDR_MTIMECMP, 32'd5, 1'b0);
		check_bit("timer_irq", 1'b0, timer_irq);
		apb_write(ADDR_CTRL, 32'h1, 1'b0);
		wait_irq(1'b1);
		apb_write(ADDR_MTIMECMPH, 32'hffff_ffff, 1'b0);
		wait_irq(1'b0);
	endtask

	// ------------------------------------------------------------------
	// main sequence

	initial begin
		errors   = 0;
		checks   = 0;
		rng      = 32'h30f949ec;
		rst_n    = 1'b0;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		paddr    = '0;
		pwdata   = '0;
		dbg_halt = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		idle_cycles(1);
		test_reset_values();
		test_write_readback();
		test_error_response();
		test_count_halt();
		test_interrupt();
		report_and_finish();
	end

endmodule

`default_nettype wire

// File: vlog.f
hw/soc_bus_pkg.sv
hw/timer_pkg.sv
hw/timer_req_if.sv
hw/apb_decode.sv
hw/timebase_tick.sv
hw/timer_regs.sv
hw/apb_response.sv
hw/periph_top.sv
tb/periph_assert.sv
tb/tb_periph.sv
